//--- common/ldpc_dec_pkg.sv
// ldpc decoder package: code size, parity table, widths and shared types
package ldpc_dec_pkg;

  //--------------------------------------------------
  // code geometry
  //--------------------------------------------------

  localparam int code_n = 16;  // code bits
  localparam int code_m = 8;   // parity checks

  localparam int llr_w  = 8;   // channel llr
  localparam int node_w = 10;  // posterior and message
  localparam int tag_w  = 4;

  // parity check matrix, one 16 bit column mask per row, row 0 at the bottom
  // row r hits columns r, r+1, 8+r and 8+((r+3) mod 8)
  // every row has weight 4, every column weight 2
  localparam logic [code_m-1:0][code_n-1:0] h_mask = {
    16'h8481,  // row 7
    16'h42c0,  // row 6
    16'h2160,  // row 5
    16'h9030,  // row 4
    16'h4818,  // row 3
    16'h240c,  // row 2
    16'h1206,  // row 1
    16'h0903   // row 0
  };

  //--------------------------------------------------
  // types
  //--------------------------------------------------

  typedef logic signed [llr_w-1:0]  llr_t;
  typedef logic signed [node_w-1:0] node_t;  // saturates symmetric
  typedef logic [3:0]               col_t;
  typedef logic [2:0]               row_t;

  // frame context, captured with the first llr address
  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic [7:0]       niter;  // 0 means bypass
    logic             fmode;  // early stop on clean syndrome
  } frame_ctx_t;

  // all posteriors of the frame
  typedef node_t [code_n-1:0] app_vec_t;

  // result of one layered row update
  typedef struct packed {
    logic     valid;
    row_t     row;
    app_vec_t app;
  } row_upd_t;

endpackage

//--- decoder/ldpc_dec_cnode.sv
// ldpc decoder check-node unit, layered normalized min-sum update of one row
module ldpc_dec_cnode #(
  parameter int norm_factor = 7  // scale is norm_factor / 8
) (
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    frame_start,
  input  logic                    row_go,
  input  ldpc_dec_pkg::row_t      row,
  input  ldpc_dec_pkg::app_vec_t  app,
  output ldpc_dec_pkg::row_upd_t  upd
);

  localparam int nw = ldpc_dec_pkg::node_w;

  // clip to +-(2^(nw-1) - 1)
  function automatic ldpc_dec_pkg::node_t sat(input logic signed [nw:0] x);
    logic signed [nw:0] lim;
    lim = {2'b00, {(nw-1){1'b1}}};
    if (x > lim) begin
      sat = ldpc_dec_pkg::node_t'(lim);
    end else if (x < -lim) begin
      sat = ldpc_dec_pkg::node_t'(-lim);
    end else begin
      sat = ldpc_dec_pkg::node_t'(x);
    end
  endfunction

  ldpc_dec_pkg::node_t c2v [ldpc_dec_pkg::code_m][ldpc_dec_pkg::code_n];  // messages

  logic [ldpc_dec_pkg::code_n-1:0] row_mask;
  ldpc_dec_pkg::node_t             v2c     [ldpc_dec_pkg::code_n];
  logic [nw-1:0]                   mag     [ldpc_dec_pkg::code_n];
  ldpc_dec_pkg::node_t             c2v_new [ldpc_dec_pkg::code_n];
  ldpc_dec_pkg::app_vec_t          app_new;
  logic [nw-1:0]                   min1, min2, sel, scl;
  ldpc_dec_pkg::col_t              min1_idx;
  logic                            sgn_all;  // xor of all v2c signs

  logic                            upd_valid;
  ldpc_dec_pkg::row_t              upd_row;
  ldpc_dec_pkg::app_vec_t          upd_app;

  assign row_mask = ldpc_dec_pkg::h_mask[row];

  //--------------------------------------------------
  // min-sum for the selected row
  //--------------------------------------------------

  always_comb begin
    min1     = '1;
    min2     = '1;
    min1_idx = '0;
    sgn_all  = 1'b0;
    for (int c = 0; c < ldpc_dec_pkg::code_n; c++) begin
      v2c[c] = sat(ldpc_dec_pkg::node_t'(app[c]) - c2v[row][c]);  // strip old message
      mag[c] = v2c[c][nw-1] ? nw'(-v2c[c]) : nw'(v2c[c]);
      if (row_mask[c]) begin
        sgn_all = sgn_all ^ v2c[c][nw-1];
        if (mag[c] < min1) begin
          min2     = min1;
          min1     = mag[c];
          min1_idx = ldpc_dec_pkg::col_t'(c);
        end else if (mag[c] < min2) begin
          min2 = mag[c];
        end
      end
    end
    sel = '0;
    scl = '0;
    for (int c = 0; c < ldpc_dec_pkg::code_n; c++) begin
      sel = (ldpc_dec_pkg::col_t'(c) == min1_idx) ? min2 : min1;  // exclude own column
      scl = nw'((sel * norm_factor) >> 3);
      // own sign removed from the product
      c2v_new[c] = (sgn_all ^ v2c[c][nw-1]) ? -ldpc_dec_pkg::node_t'(scl)
                                            :  ldpc_dec_pkg::node_t'(scl);
      app_new[c] = row_mask[c] ? sat(v2c[c] + c2v_new[c]) : app[c];
    end
  end

  //--------------------------------------------------
  // registers
  //--------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      upd_valid <= 1'b0;
    end else begin
      upd_valid <= row_go;  // update one cycle after row_go
    end
  end

  always_ff @(posedge iclk) begin
    upd_row <= row;
    upd_app <= app_new;
    if (frame_start) begin
      c2v <= '{default: '0};
    end else if (row_go) begin
      for (int c = 0; c < ldpc_dec_pkg::code_n; c++) begin
        if (row_mask[c]) c2v[row][c] <= c2v_new[c];
      end
    end
  end

  assign upd = {upd_valid, upd_row, upd_app};

endmodule

//--- decoder/ldpc_dec_ctrl.sv
// ldpc decoder frame sequencer, runs load, layered iterations, early stop and output
module ldpc_dec_ctrl (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      buf_full,
  input  logic                      obuf_empty,
  input  ldpc_dec_pkg::frame_ctx_t  ctx,
  input  logic                      load_done,
  input  logic                      syn_ok,
  input  logic                      out_done,
  output logic                      load_go,
  output logic                      frame_start,
  output logic                      row_go,
  output ldpc_dec_pkg::row_t        row,
  output logic                      out_go,
  output logic                      fail
);

  localparam ldpc_dec_pkg::row_t last_row = ldpc_dec_pkg::row_t'(ldpc_dec_pkg::code_m - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_iter,
    st_out
  } state_t;

  state_t     state;
  logic       ph;        // 0 issue row, 1 row update lands
  logic [7:0] iter_cnt;  // finished iterations
  logic       start;
  logic       done;

  //--------------------------------------------------
  // decisions
  //--------------------------------------------------

  assign start       = (state == st_idle) && buf_full && obuf_empty;  // waits on back-pressure
  assign load_go     = start;
  assign frame_start = start;  // clears the c2v messages

  // checked at row 0 only, i.e. at iteration boundaries
  // niter of 0 hits at once, which is the bypass
  assign done   = (iter_cnt == ctx.niter) || (ctx.fmode && syn_ok && iter_cnt != '0);
  assign out_go = (state == st_iter) && !ph && (row == '0) && done;
  assign row_go = (state == st_iter) && !ph && !out_go;

  //--------------------------------------------------
  // state
  //--------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= st_idle;
      ph       <= 1'b0;
      row      <= '0;
      iter_cnt <= '0;
      fail     <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start) state <= st_load;
        end
        st_load: begin
          if (load_done) begin
            state    <= st_iter;
            ph       <= 1'b0;
            row      <= '0;
            iter_cnt <= '0;
          end
        end
        st_iter: begin
          if (out_go) begin
            state <= st_out;
            fail  <= !syn_ok;  // held until the next frame
          end else if (ph) begin
            ph  <= 1'b0;
            row <= row + 1'b1;  // wraps to row 0
            if (row == last_row) iter_cnt <= iter_cnt + 1'b1;
          end else begin
            ph <= 1'b1;
          end
        end
        default: begin  // st_out
          if (out_done) state <= st_idle;
        end
      endcase
    end
  end

endmodule

//--- decoder/ldpc_dec_vnode.sv
// ldpc decoder variable-node unit, posterior store with hard decisions and syndrome check
module ldpc_dec_vnode (
  input  logic                             iclk,
  input  logic                             ireset,
  input  logic                             load_wr,
  input  ldpc_dec_pkg::col_t               load_col,
  input  ldpc_dec_pkg::llr_t               load_llr,
  input  ldpc_dec_pkg::row_upd_t           upd,
  output ldpc_dec_pkg::app_vec_t           app,
  output logic [ldpc_dec_pkg::code_n-1:0]  hard,
  output logic                             syn_ok
);

  ldpc_dec_pkg::app_vec_t           app_nxt;
  logic [ldpc_dec_pkg::code_n-1:0]  hard_nxt;
  logic [ldpc_dec_pkg::code_m-1:0]  chk_bad;  // odd parity per row

  // next posteriors, load and row update never overlap
  always_comb begin
    app_nxt = app;
    if (upd.valid) begin
      app_nxt = upd.app;
    end
    if (load_wr) begin
      app_nxt[load_col] = {{(ldpc_dec_pkg::node_w - ldpc_dec_pkg::llr_w)
                            {load_llr[ldpc_dec_pkg::llr_w-1]}}, load_llr};  // sign extend
    end
    for (int c = 0; c < ldpc_dec_pkg::code_n; c++) begin
      hard_nxt[c] = app_nxt[c][ldpc_dec_pkg::node_w-1];  // negative -> 1
    end
    for (int r = 0; r < ldpc_dec_pkg::code_m; r++) begin
      chk_bad[r] = ^(hard_nxt & ldpc_dec_pkg::h_mask[r]);
    end
  end

  always_ff @(posedge iclk) begin
    app <= app_nxt;
  end

  // syndrome tracks app in the same cycle
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      syn_ok <= 1'b0;
    end else begin
      syn_ok <= ~|chk_bad;
    end
  end

  always_comb begin
    for (int c = 0; c < ldpc_dec_pkg::code_n; c++) begin
      hard[c] = app[c][ldpc_dec_pkg::node_w-1];
    end
  end

endmodule

//--- list.f
common/ldpc_dec_pkg.sv
verilog/ldpc_dec_loader.sv
decoder/ldpc_dec_ctrl.sv
decoder/ldpc_dec_cnode.sv
decoder/ldpc_dec_vnode.sv
verilog/ldpc_dec_out.sv
verilog/ldpc_dec_top.sv
verif/ldpc_dec_properties.sv
verif/tb_ldpc_dec.sv

//--- verif/ldpc_dec_properties.sv
// ldpc decoder protocol checker, concurrent assertions bound into the top level
module ldpc_dec_properties (
  input logic               iclk,
  input logic               ireset,
  input ldpc_dec_pkg::col_t llr_raddr,
  input logic               buf_rempty,
  input logic               obuf_empty,
  input logic               write,
  input ldpc_dec_pkg::col_t waddr,
  input logic               wfull
);

  localparam ldpc_dec_pkg::col_t last_col = ldpc_dec_pkg::col_t'(ldpc_dec_pkg::code_n - 1);

  int   fail_cnt = 0;  // failed assertions so far
  logic act;           // frame past its first address, up to wfull
  logic held;          // input buffer released, output not done yet

  task automatic count_fail(input string msg);
    fail_cnt++;
    $error("[FAIL] %0t %s", $time, msg);
  endtask

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      act  <= 1'b0;
      held <= 1'b0;
    end else begin
      if (wfull) begin
        act  <= 1'b0;
        held <= 1'b0;
      end else begin
        if (llr_raddr != '0) act <= 1'b1;  // address counter moving
        if (buf_rempty) held <= 1'b1;
      end
    end
  end

  //--------------------------------------------------
  // reset and input side
  //--------------------------------------------------

  a_reset_quiet: assert property (@(posedge iclk)
    $fell(ireset) |-> !write && !wfull && !buf_rempty && llr_raddr == '0)
    else count_fail("outputs not at rest after reset");

  // one release per frame, one cycle wide
  a_rempty_once: assert property (@(posedge iclk) disable iff (ireset)
    buf_rempty |-> !held)
    else count_fail("buf_rempty repeated within a frame");

  // idle and output buffer busy
  a_backpress: assert property (@(posedge iclk) disable iff (ireset)
    !obuf_empty && !act |=> $stable(llr_raddr) && !write)
    else count_fail("activity while output buffer not empty");

  //--------------------------------------------------
  // output write sequence
  //--------------------------------------------------

  a_first_addr: assert property (@(posedge iclk) disable iff (ireset)
    $rose(write) |-> waddr == '0)
    else count_fail("first write not at address 0");

  a_addr_step: assert property (@(posedge iclk) disable iff (ireset)
    write && waddr != last_col |=> write && waddr == $past(waddr) + 4'd1)
    else count_fail("write burst broken or out of order");

  a_last_wr: assert property (@(posedge iclk) disable iff (ireset)
    write && waddr == last_col |=> wfull && !write)
    else count_fail("wfull missing after last write");

  a_wfull_src: assert property (@(posedge iclk) disable iff (ireset)
    wfull |-> $past(write && waddr == last_col))
    else count_fail("wfull without a finished write burst");

endmodule

bind ldpc_dec_top ldpc_dec_properties props (
  .iclk       (iclk),
  .ireset     (ireset),
  .llr_raddr  (llr_raddr),
  .buf_rempty (buf_rempty),
  .obuf_empty (obuf_empty),
  .write      (write),
  .waddr      (waddr),
  .wfull      (wfull)
);

//--- verif/tb_ldpc_dec.sv
// ldpc decoder testbench, runs clean, corrected, bypass, back-pressure and early stop frames
module tb_ldpc_dec;

  localparam int err_w     = 16;
  localparam int n_frames  = 5;
  localparam int niter_max = 8;
  localparam int margin    = 40;  // reset, back-pressure hold, drain
  localparam int limit     = n_frames * (17 + 16 * niter_max + 18 + margin);
  localparam int early_max = 17 + 16 + 2;  // first address to first write

  logic                            iclk = 1'b0;
  logic                            ireset;
  logic                            buf_full;
  ldpc_dec_pkg::llr_t              llr;
  logic [ldpc_dec_pkg::tag_w-1:0]  tag;
  logic [7:0]                      niter;
  logic                            fmode;
  logic                            obuf_empty;
  ldpc_dec_pkg::col_t              llr_raddr;
  logic                            buf_rempty;
  logic                            write;
  ldpc_dec_pkg::col_t              waddr;
  logic                            wdat;
  logic [ldpc_dec_pkg::tag_w-1:0]  wtag;
  logic                            decfail;
  logic                            wfull;
  logic [err_w-1:0]                err;

  ldpc_dec_pkg::llr_t              chan [ldpc_dec_pkg::code_n];  // input buffer
  logic [ldpc_dec_pkg::code_n-1:0] exp_bits;
  logic                            exp_fail;
  int                              exp_err;
  logic [ldpc_dec_pkg::tag_w-1:0]  cur_tag;
  int                              cyc          = 0;
  int                              errors       = 0;
  int                              timeouts     = 0;
  integer                          seed         = 32757;
  int                              flip_col;
  int                              addr1_cyc    = -1;  // cycle of address 1
  int                              first_wr_cyc = -1;

  ldpc_dec_top #(.norm_factor(7), .err_w(err_w)) UUT (.*);

  always #20 iclk = ~iclk;

  task automatic report_mismatch(input string what, input int got, input int want);
    errors++;
    $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, want);
  endtask

  task automatic finish_run;
    $display("summary: %0d value errors, %0d assertion failures, %0d timeouts",
             errors, UUT.props.fail_cnt, timeouts);
    if (errors == 0 && UUT.props.fail_cnt == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  //--------------------------------------------------
  // watchdog and input buffer
  //--------------------------------------------------

  always @(posedge iclk) begin
    cyc++;
    if (cyc >= limit) begin
      timeouts++;
      $display("timeout: frames did not complete within %0d cycles", limit);
      finish_run();
    end
  end

  always @(posedge iclk) begin
    llr <= chan[llr_raddr];  // answers last cycle's address
  end

  // output buffer side, sampled mid-cycle
  always @(negedge iclk) begin
    if (llr_raddr == 4'd1 && addr1_cyc < 0) addr1_cyc = cyc;
    if (write) begin
      if (first_wr_cyc < 0) first_wr_cyc = cyc;
      assert (wdat == exp_bits[waddr]) else report_mismatch("wdat", wdat, exp_bits[waddr]);
      assert (wtag == cur_tag) else report_mismatch("wtag", wtag, cur_tag);
      assert (decfail == exp_fail) else report_mismatch("decfail", decfail, exp_fail);
    end
    if (wfull) begin
      assert (err == exp_err) else report_mismatch("err", err, exp_err);
    end
  end

  //--------------------------------------------------
  // frame helpers
  //--------------------------------------------------

  // strong zeros, one weak wrong bit unless weak_col is -1
  task automatic fill_frame(input int weak_col);
    for (int c = 0; c < ldpc_dec_pkg::code_n; c++) begin
      chan[c] = (c == weak_col) ? ldpc_dec_pkg::llr_t'(-20) : ldpc_dec_pkg::llr_t'(100);
    end
  endtask

  // decoded frames come out all zero, bypass gives back the channel signs
  task automatic set_expect(input logic bypass);
    exp_err  = 0;
    exp_fail = 1'b0;
    for (int c = 0; c < ldpc_dec_pkg::code_n; c++) begin
      exp_bits[c] = bypass ? chan[c][ldpc_dec_pkg::llr_w-1] : 1'b0;
      if (exp_bits[c] != chan[c][ldpc_dec_pkg::llr_w-1]) exp_err++;  // a correction
    end
    for (int r = 0; r < ldpc_dec_pkg::code_m; r++) begin
      if (^(exp_bits & ldpc_dec_pkg::h_mask[r])) exp_fail = 1'b1;  // odd check
    end
  endtask

  task automatic run_frame(input logic [3:0] t, input logic [7:0] n, input logic f,
                           input int hold, input logic check_early);
    cur_tag      = t;
    addr1_cyc    = -1;
    first_wr_cyc = -1;
    @(posedge iclk);
    tag      <= t;
    niter    <= n;
    fmode    <= f;
    buf_full <= 1'b1;
    if (hold > 0) begin
      obuf_empty <= 1'b0;  // output buffer busy, frame waits
      repeat (hold) @(posedge iclk);
      obuf_empty <= 1'b1;
    end
    do @(negedge iclk); while (!buf_rempty);
    @(posedge iclk);
    buf_full <= 1'b0;  // buffer released
    do @(negedge iclk); while (!wfull);
    if (check_early) begin
      assert (first_wr_cyc - addr1_cyc + 1 <= early_max)
        else report_mismatch("cycles to first write, limit", first_wr_cyc - addr1_cyc + 1,
                             early_max);
    end
    @(posedge iclk);  // let the wfull checks finish first
  endtask

  //--------------------------------------------------
  // test sequence
  //--------------------------------------------------

  initial begin
    ireset     = 1'b1;
    buf_full   = 1'b0;
    llr        = '0;
    tag        = '0;
    niter      = '0;
    fmode      = 1'b0;
    obuf_empty = 1'b1;
    fill_frame(-1);
    set_expect(1'b0);
    cur_tag    = '0;
    flip_col   = $unsigned($random(seed)) % ldpc_dec_pkg::code_n;
    repeat (8) @(posedge iclk);
    ireset <= 1'b0;

    run_frame(4'd1, 8'd4, 1'b0, 0, 1'b0);  // clean
    fill_frame(flip_col);
    set_expect(1'b0);
    run_frame(4'd2, 8'd4, 1'b0, 0, 1'b0);  // weak wrong bit, corrected
    set_expect(1'b1);
    run_frame(4'd3, 8'd0, 1'b0, 0, 1'b0);  // same frame, bypass
    fill_frame(-1);
    set_expect(1'b0);
    run_frame(4'd4, 8'd2, 1'b0, 20, 1'b0);  // behind a busy output buffer
    run_frame(4'd5, 8'd8, 1'b1, 0, 1'b1);   // early stop after one pass

    repeat (4) @(posedge iclk);
    finish_run();
  end

endmodule

//--- verilog/ldpc_dec_loader.sv
// ldpc decoder input side, reads the channel llrs and releases the input buffer
module ldpc_dec_loader (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            load_go,
  input  ldpc_dec_pkg::llr_t              llr,      // one cycle after its address
  input  logic [ldpc_dec_pkg::tag_w-1:0]  tag,
  input  logic [7:0]                      niter,
  input  logic                            fmode,
  output ldpc_dec_pkg::col_t              llr_raddr,
  output logic                            buf_rempty,
  output logic                            load_wr,
  output ldpc_dec_pkg::col_t              load_col,
  output ldpc_dec_pkg::llr_t              load_llr,
  output ldpc_dec_pkg::frame_ctx_t        ctx,
  output logic                            load_done
);

  localparam ldpc_dec_pkg::col_t last_col = ldpc_dec_pkg::col_t'(ldpc_dec_pkg::code_n - 1);

  logic rd_act;  // address phase running

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_act     <= 1'b0;
      llr_raddr  <= '0;
      load_wr    <= 1'b0;
      buf_rempty <= 1'b0;
    end else begin
      if (load_go) begin
        rd_act <= 1'b1;
      end else if (rd_act && llr_raddr == last_col) begin
        rd_act <= 1'b0;
      end
      if (rd_act) begin
        llr_raddr <= llr_raddr + 1'b1;  // wraps back to 0 after the frame
      end
      load_wr    <= rd_act;                            // llr returns now
      buf_rempty <= load_wr && (load_col == last_col);  // after last capture
    end
  end

  // address pipe and context capture
  always_ff @(posedge iclk) begin
    load_col <= llr_raddr;
    if (rd_act && llr_raddr == '0) begin
      ctx <= '{tag: tag, niter: niter, fmode: fmode};
    end
  end

  assign load_llr  = llr;         // paired with load_col
  assign load_done = buf_rempty;  // frame fully in the vnode unit

endmodule

//--- verilog/ldpc_dec_out.sv
// ldpc decoder output side, writes hard bits, counts corrections and flags completion
module ldpc_dec_out #(
  parameter int err_w = 16
) (
  input  logic                             iclk,
  input  logic                             ireset,
  input  logic                             out_go,
  input  logic [ldpc_dec_pkg::code_n-1:0]  hard,
  input  ldpc_dec_pkg::frame_ctx_t         ctx,
  input  logic                             fail,
  input  logic                             load_wr,
  input  ldpc_dec_pkg::col_t               load_col,
  input  ldpc_dec_pkg::llr_t               load_llr,
  output logic                             out_done,
  output logic                             write,
  output ldpc_dec_pkg::col_t               waddr,
  output logic                             wdat,
  output logic [ldpc_dec_pkg::tag_w-1:0]   wtag,
  output logic                             decfail,
  output logic                             wfull,
  output logic [err_w-1:0]                 err
);

  localparam ldpc_dec_pkg::col_t last_col = ldpc_dec_pkg::col_t'(ldpc_dec_pkg::code_n - 1);

  logic [ldpc_dec_pkg::code_n-1:0] chan_q;  // channel hard decisions
  logic [ldpc_dec_pkg::code_n-1:0] hard_q;  // decoded bits, frozen at out_go
  logic                            last_wr;

  assign last_wr = write && (waddr == last_col);

  //--------------------------------------------------
  // write sequence and error count
  //--------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      write <= 1'b0;
      waddr <= '0;
      wfull <= 1'b0;
      err   <= '0;
    end else begin
      if (out_go) begin
        write <= 1'b1;
      end else if (last_wr) begin
        write <= 1'b0;
      end
      if (write) begin
        waddr <= waddr + 1'b1;  // back to 0 after bit 15
      end
      wfull <= last_wr;  // cycle after last write
      if (out_go) begin
        err <= '0;
      end else if (write && wdat != chan_q[waddr]) begin
        err <= err + 1'b1;  // bit flipped by the decoder
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (load_wr) begin
      chan_q[load_col] <= load_llr[ldpc_dec_pkg::llr_w-1];
    end
    if (out_go) begin
      hard_q <= hard;
      wtag   <= ctx.tag;  // held for the frame
    end
  end

  assign wdat     = hard_q[waddr];
  assign decfail  = fail;
  assign out_done = wfull;

endmodule

//--- verilog/ldpc_dec_top.sv
// ldpc decoder top level, ties input side, sequencer, node units and output side together
module ldpc_dec_top #(
  parameter int norm_factor = 7,   // min-sum scale, norm_factor / 8
  parameter int err_w       = 16
) (
  input  logic                                iclk,
  input  logic                                ireset,
  // input buffer
  input  logic                                buf_full,
  input  ldpc_dec_pkg::llr_t                  llr,
  input  logic [ldpc_dec_pkg::tag_w-1:0]      tag,
  input  logic [7:0]                          niter,
  input  logic                                fmode,
  output ldpc_dec_pkg::col_t                  llr_raddr,
  output logic                                buf_rempty,
  // output buffer
  input  logic                                obuf_empty,
  output logic                                write,
  output ldpc_dec_pkg::col_t                  waddr,
  output logic                                wdat,
  output logic [ldpc_dec_pkg::tag_w-1:0]      wtag,
  output logic                                decfail,
  output logic                                wfull,
  output logic [err_w-1:0]                    err
);

  //--------------------------------------------------
  // internal nets
  //--------------------------------------------------

  logic                              load_go;
  logic                              frame_start;
  logic                              load_wr;      // one per captured llr
  ldpc_dec_pkg::col_t                load_col;
  ldpc_dec_pkg::llr_t                load_llr;
  ldpc_dec_pkg::frame_ctx_t          ctx;
  logic                              load_done;
  logic                              row_go;
  ldpc_dec_pkg::row_t                row;
  ldpc_dec_pkg::app_vec_t            app;
  ldpc_dec_pkg::row_upd_t            upd;
  logic [ldpc_dec_pkg::code_n-1:0]   hard;
  logic                              syn_ok;
  logic                              out_go;
  logic                              fail;
  logic                              out_done;

  //--------------------------------------------------
  // blocks
  //--------------------------------------------------

  ldpc_dec_loader loader (
    .iclk       (iclk),
    .ireset     (ireset),
    .load_go    (load_go),
    .llr        (llr),
    .tag        (tag),
    .niter      (niter),
    .fmode      (fmode),
    .llr_raddr  (llr_raddr),
    .buf_rempty (buf_rempty),
    .load_wr    (load_wr),
    .load_col   (load_col),
    .load_llr   (load_llr),
    .ctx        (ctx),
    .load_done  (load_done)
  );

  ldpc_dec_ctrl ctrl (
    .iclk        (iclk),
    .ireset      (ireset),
    .buf_full    (buf_full),
    .obuf_empty  (obuf_empty),
    .ctx         (ctx),
    .load_done   (load_done),
    .syn_ok      (syn_ok),
    .out_done    (out_done),
    .load_go     (load_go),
    .frame_start (frame_start),
    .row_go      (row_go),
    .row         (row),
    .out_go      (out_go),
    .fail        (fail)
  );

  ldpc_dec_cnode #(
    .norm_factor (norm_factor)
  ) cnode (
    .iclk        (iclk),
    .ireset      (ireset),
    .frame_start (frame_start),
    .row_go      (row_go),
    .row         (row),
    .app         (app),
    .upd         (upd)
  );

  ldpc_dec_vnode vnode (
    .iclk     (iclk),
    .ireset   (ireset),
    .load_wr  (load_wr),
    .load_col (load_col),
    .load_llr (load_llr),
    .upd      (upd),
    .app      (app),
    .hard     (hard),
    .syn_ok   (syn_ok)
  );

  ldpc_dec_out #(
    .err_w (err_w)
  ) out (
    .iclk     (iclk),
    .ireset   (ireset),
    .out_go   (out_go),
    .hard     (hard),
    .ctx      (ctx),
    .fail     (fail),
    .load_wr  (load_wr),
    .load_col (load_col),
    .load_llr (load_llr),
    .out_done (out_done),
    .write    (write),
    .waddr    (waddr),
    .wdat     (wdat),
    .wtag     (wtag),
    .decfail  (decfail),
    .wfull    (wfull),
    .err      (err)
  );

endmodule
